// ==== Makefile ====
TOP := core_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f sources.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) -o $(TOP)
	@out=$$(./obj_dir/$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf obj_dir

// ==== sources.f ====
+incdir+verilog
verilog/core_pkg.sv
verilog/register_file.sv
verilog/ifu.sv
verilog/idu.sv
verilog/exu.sv
verilog/lsu.sv
verilog/wbu.sv
verilog/core_top.sv
tests/core_chk.sv
tests/core_monitor.sv
tests/core_tb.sv

// ==== tests/core_chk.sv ====
`timescale 1ns/1ps

module core_chk (
    input logic              clk,
    input logic              rst_n_i,
    input core_pkg::wb_req_s imem_req_i,
    input core_pkg::wb_rsp_s imem_rsp_i,
    input core_pkg::wb_req_s dmem_req_i,
    input core_pkg::wb_rsp_s dmem_rsp_i,
    input logic              retire_valid_i
);

    int error_count = 0;

    stb_with_cyc: assert property (@(posedge clk) disable iff (!rst_n_i)
        (!imem_req_i.stb || imem_req_i.cyc) && (!dmem_req_i.stb || dmem_req_i.cyc))
        else begin
            $error("stb high without cyc");
            error_count++;
        end

    // Address held until the slave acks
    imem_adr_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
        (imem_req_i.stb && !imem_rsp_i.ack) |=> $stable(imem_req_i.adr))
        else begin
            $error("imem adr changed during a wait state");
            error_count++;
        end

    dmem_adr_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
        (dmem_req_i.stb && !dmem_rsp_i.ack) |=> $stable(dmem_req_i.adr))
        else begin
            $error("dmem adr changed during a wait state");
            error_count++;
        end

    retire_pulse: assert property (@(posedge clk) disable iff (!rst_n_i)
        retire_valid_i |=> !retire_valid_i)
        else begin
            $error("retire_valid_o high for more than one cycle");
            error_count++;
        end

    idle_after_reset: assert property (@(posedge clk)
        !rst_n_i |=> (!imem_req_i.cyc && !dmem_req_i.cyc && !retire_valid_i))
        else begin
            $error("bus request or retire active right after reset");
            error_count++;
        end

endmodule

bind core_top core_chk chk0 (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .imem_req_i     (imem_req_o),
    .imem_rsp_i     (imem_rsp_i),
    .dmem_req_i     (dmem_req_o),
    .dmem_rsp_i     (dmem_rsp_i),
    .retire_valid_i (retire_valid_o)
);

// ==== tests/core_monitor.sv ====
`timescale 1ns/1ps

module core_monitor #(
    parameter int num_tests = 1
) (
    input  logic                              clk,
    input  logic                              rst_n_i,
    input  logic                              retire_valid_i,
    input  core_pkg::retire_s                 retire_i,
    input  core_pkg::retire_s [num_tests-1:0] expected_i,
    output logic                              done_o,
    output int                                fail_count_o
);

    int                entry;
    int                pass_count;
    logic              match;
    core_pkg::retire_s want;

    always @(posedge clk) begin
        if (!rst_n_i) begin
            entry        = 0;
            pass_count   = 0;
            fail_count_o = 0;
            done_o       = 1'b0;
        end else if (retire_valid_i && !done_o) begin
            want  = expected_i[entry];
            match = (retire_i.pc == want.pc) && (retire_i.we == want.we);
            // Destination only matters when a register is written
            if (want.we) begin
                match = match && (retire_i.rd == want.rd) && (retire_i.wdata == want.wdata);
            end
            if (match) begin
                pass_count++;
                $display("test %0d: pc %h ok", entry, retire_i.pc);
            end else begin
                fail_count_o++;
                $display("error: %0t test %0d pc %h/%h rd %0d/%0d we %b/%b wdata %h/%h",
                         $time, entry, retire_i.pc, want.pc, retire_i.rd, want.rd,
                         retire_i.we, want.we, retire_i.wdata, want.wdata);
            end
            entry++;
            if (entry == num_tests) begin
                done_o = 1'b1;
                $display("%0d passed, %0d failed", pass_count, fail_count_o);
            end
        end
    end

endmodule

// ==== tests/core_tb.sv ====
`timescale 1ns/1ps

module core_tb;

    localparam int num_tests      = 18;
    localparam int timeout_cycles = num_tests * 20;
    localparam int mem_words      = 64;

    // RV32I major opcodes used by the encoders
    localparam logic [6:0] op_imm  = 7'b0010011;
    localparam logic [6:0] op_load = 7'b0000011;

    // One program step and the retire record it must produce
    typedef struct packed {
        logic [31:0] inst;
        logic [31:0] pc;
        logic [4:0]  rd;
        logic        we;
        logic [31:0] wdata;
    } prog_entry_s;

    logic              clk;
    logic              rst_n;
    core_pkg::wb_req_s imem_req;
    core_pkg::wb_rsp_s imem_rsp;
    core_pkg::wb_req_s dmem_req;
    core_pkg::wb_rsp_s dmem_rsp;
    core_pkg::retire_s retire;
    logic              retire_valid;
    logic              check_done;
    int                fail_count;
    int                cycles;

    prog_entry_s                       prog [num_tests];
    core_pkg::retire_s [num_tests-1:0] expected;
    logic [31:0]                       imem [mem_words];
    logic [31:0]                       dmem [mem_words];

    logic [31:0] rand_state = 32'h8e0b_a185;
    int          imem_wait  = -1;
    int          dmem_wait  = -1;

    function automatic logic [31:0] lcg_next(logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] encode_r(logic [6:0] f7, logic [4:0] rd,
                                             logic [4:0] rs1, logic [4:0] rs2);
        return {f7, rs2, rs1, 3'b000, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] encode_i(logic [6:0] op, logic [2:0] f3, logic [4:0] rd,
                                             logic [4:0] rs1, logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] encode_s(logic [4:0] rs1, logic [4:0] rs2, logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] encode_b(logic [4:0] rs1, logic [4:0] rs2, logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, 3'b000, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] encode_u(logic [4:0] rd, logic [19:0] imm);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic logic [31:0] encode_j(logic [4:0] rd, logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    // Program in retire order with each word placed at its own pc
    task automatic load_program();
        prog[0]  = '{encode_i(op_imm, 3'd0, 5'd1, 5'd0, 12'd5), 32'h00, 5'd1, 1'b1, 32'h5};
        prog[1]  = '{encode_i(op_imm, 3'd0, 5'd2, 5'd0, 12'hffd), 32'h04, 5'd2, 1'b1,
                     32'hffff_fffd};
        prog[2]  = '{encode_r(7'h00, 5'd3, 5'd1, 5'd2), 32'h08, 5'd3, 1'b1, 32'h2};
        prog[3]  = '{encode_r(7'h20, 5'd4, 5'd1, 5'd2), 32'h0c, 5'd4, 1'b1, 32'h8};
        prog[4]  = '{encode_u(5'd5, 20'h12345), 32'h10, 5'd5, 1'b1, 32'h1234_5000};
        prog[5]  = '{encode_i(op_imm, 3'd0, 5'd5, 5'd5, 12'h678), 32'h14, 5'd5, 1'b1,
                     32'h1234_5678};
        // Write to x0 is dropped
        prog[6]  = '{encode_i(op_imm, 3'd0, 5'd0, 5'd1, 12'd7), 32'h18, 5'd0, 1'b0, 32'h0};
        prog[7]  = '{encode_s(5'd0, 5'd5, 12'h040), 32'h1c, 5'd0, 1'b0, 32'h0};
        prog[8]  = '{encode_s(5'd0, 5'd4, 12'h044), 32'h20, 5'd0, 1'b0, 32'h0};
        prog[9]  = '{encode_i(op_load, 3'd2, 5'd6, 5'd0, 12'h040), 32'h24, 5'd6, 1'b1,
                     32'h1234_5678};
        prog[10] = '{encode_i(op_load, 3'd2, 5'd7, 5'd0, 12'h044), 32'h28, 5'd7, 1'b1, 32'h8};
        // Unequal then equal operands
        prog[11] = '{encode_b(5'd1, 5'd2, 13'd8), 32'h2c, 5'd0, 1'b0, 32'h0};
        prog[12] = '{encode_b(5'd6, 5'd5, 13'd12), 32'h30, 5'd0, 1'b0, 32'h0};
        prog[13] = '{encode_j(5'd8, 21'd16), 32'h3c, 5'd8, 1'b1, 32'h40};
        prog[14] = '{encode_r(7'h00, 5'd9, 5'd8, 5'd7), 32'h4c, 5'd9, 1'b1, 32'h48};
        prog[15] = '{encode_r(7'h20, 5'd10, 5'd0, 5'd1), 32'h50, 5'd10, 1'b1, 32'hffff_fffb};
        prog[16] = '{encode_j(5'd0, 21'd8), 32'h54, 5'd0, 1'b0, 32'h0};
        prog[17] = '{encode_i(op_imm, 3'd0, 5'd11, 5'd10, 12'd5), 32'h5c, 5'd11, 1'b1, 32'h0};

        // Skipped slots write x31 with their own word index
        for (int i = 0; i < mem_words; i++) begin
            imem[i] = encode_i(op_imm, 3'd0, 5'd31, 5'd0, 12'(i));
            dmem[i] = 32'hd0d0_0000 + 32'(i) * 32'd4;
        end
        for (int i = 0; i < num_tests; i++) begin
            imem[prog[i].pc[7:2]] = prog[i].inst;
            expected[i] = '{pc: prog[i].pc, rd: prog[i].rd, we: prog[i].we,
                            wdata: prog[i].wdata};
        end
    endtask

    always #10 clk = ~clk;

    // Wishbone slaves with 0 to 3 random wait states
    always @(posedge clk) begin
        #1;
        if (imem_rsp.ack) begin
            imem_rsp.ack = 1'b0;
        end else if (imem_req.cyc && imem_req.stb) begin
            if (imem_wait < 0) begin
                rand_state = lcg_next(rand_state);
                imem_wait  = int'(rand_state[17:16]);
            end
            if (imem_wait == 0) begin
                imem_rsp.ack   = 1'b1;
                imem_rsp.dat_r = imem[imem_req.adr[7:2]];
                imem_wait      = -1;
            end else begin
                imem_wait--;
            end
        end
        if (dmem_rsp.ack) begin
            dmem_rsp.ack = 1'b0;
        end else if (dmem_req.cyc && dmem_req.stb) begin
            if (dmem_wait < 0) begin
                rand_state = lcg_next(rand_state);
                dmem_wait  = int'(rand_state[17:16]);
            end
            if (dmem_wait == 0) begin
                if (dmem_req.we) begin
                    // Only the byte lanes selected by sel are written
                    for (int b = 0; b < 4; b++) begin
                        if (dmem_req.sel[b]) begin
                            dmem[dmem_req.adr[7:2]][8*b +: 8] = dmem_req.dat_w[8*b +: 8];
                        end
                    end
                end
                dmem_rsp.ack   = 1'b1;
                dmem_rsp.dat_r = dmem[dmem_req.adr[7:2]];
                dmem_wait      = -1;
            end else begin
                dmem_wait--;
            end
        end
    end

    core_top dut0 (
        .clk            (clk),
        .rst_n_i        (rst_n),
        .imem_rsp_i     (imem_rsp),
        .dmem_rsp_i     (dmem_rsp),
        .imem_req_o     (imem_req),
        .dmem_req_o     (dmem_req),
        .retire_o       (retire),
        .retire_valid_o (retire_valid)
    );

    core_monitor #(
        .num_tests (num_tests)
    ) mon0 (
        .clk            (clk),
        .rst_n_i        (rst_n),
        .retire_valid_i (retire_valid),
        .retire_i       (retire),
        .expected_i     (expected),
        .done_o         (check_done),
        .fail_count_o   (fail_count)
    );

    initial begin
        clk      = 1'b0;
        rst_n    = 1'b0;
        imem_rsp = '0;
        dmem_rsp = '0;
        cycles   = 0;
        load_program();
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        while (!check_done && cycles < timeout_cycles) begin
            @(negedge clk);
            cycles++;
        end
        if (!check_done) begin
            $display("timeout: core stopped retiring instructions");
        end
        if (check_done && fail_count == 0 && dut0.chk0.error_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== verilog/core_config.svh ====
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// Data path width
`define CORE_XLEN 32

// First instruction fetched after reset
`define CORE_RESET_PC 32'h0000_0000

// Register file addressing
`define CORE_REG_AW 5
`define CORE_REG_X0 5'd0

`endif

// ==== verilog/core_pkg.sv ====
`include "core_config.svh"

package core_pkg;

    // RV32I major opcodes handled by the core
    typedef enum logic [6:0] {
        OP_IMM = 7'b0010011,
        OP     = 7'b0110011,
        LUI    = 7'b0110111,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [1:0] {
        ALU_ADD   = 2'd0,
        ALU_SUB   = 2'd1,
        ALU_PASSB = 2'd2
    } alu_op_e;

    // Shared by the IFU and LSU sequencers
    typedef enum logic [2:0] {
        IDLE,
        FETCH_REQ,
        FETCH_WAIT,
        ACCESS,
        DONE
    } stage_state_e;

    typedef struct packed {
        logic                   valid;
        logic [`CORE_XLEN-1:0]  pc;
        logic [31:0]            inst;
    } fetch_s;

    typedef struct packed {
        logic                   valid;
        logic [`CORE_XLEN-1:0]  pc;
        logic [`CORE_XLEN-1:0]  op1;
        logic [`CORE_XLEN-1:0]  op2;
        logic [`CORE_XLEN-1:0]  rs2_data;
        logic [`CORE_REG_AW-1:0] rd;
        alu_op_e                alu_op;
        opcode_e                opcode;
        logic                   taken;
        logic [`CORE_XLEN-1:0]  target;
    } decode_s;

    typedef struct packed {
        logic                   valid;
        logic [`CORE_XLEN-1:0]  pc;
        logic [`CORE_XLEN-1:0]  result;
        logic [`CORE_XLEN-1:0]  rs2_data;
        logic [`CORE_REG_AW-1:0] rd;
        opcode_e                opcode;
    } exec_s;

    typedef struct packed {
        logic                   valid;
        logic [`CORE_XLEN-1:0]  pc;
        logic [`CORE_XLEN-1:0]  result;
        logic [`CORE_XLEN-1:0]  load_data;
        logic [`CORE_REG_AW-1:0] rd;
        opcode_e                opcode;
    } mem_s;

    typedef struct packed {
        logic                   taken;
        logic [`CORE_XLEN-1:0]  target;
    } redirect_s;

    // Observation record for one retired instruction
    typedef struct packed {
        logic [`CORE_XLEN-1:0]  pc;
        logic [`CORE_REG_AW-1:0] rd;
        logic                   we;
        logic [`CORE_XLEN-1:0]  wdata;
    } retire_s;

    // Wishbone classic master bundles
    typedef struct packed {
        logic                   cyc;
        logic                   stb;
        logic                   we;
        logic [`CORE_XLEN-1:0]  adr;
        logic [`CORE_XLEN-1:0]  dat_w;
        logic [3:0]             sel;
    } wb_req_s;

    typedef struct packed {
        logic                   ack;
        logic [`CORE_XLEN-1:0]  dat_r;
    } wb_rsp_s;

endpackage

// ==== verilog/core_top.sv ====
`timescale 1ns/1ps
`include "core_config.svh"

module core_top (
    input  logic              clk,
    input  logic              rst_n_i,
    input  core_pkg::wb_rsp_s imem_rsp_i,
    input  core_pkg::wb_rsp_s dmem_rsp_i,
    output core_pkg::wb_req_s imem_req_o,
    output core_pkg::wb_req_s dmem_req_o,
    output core_pkg::retire_s retire_o,
    output logic              retire_valid_o
);

    // Register file ports
    logic [`CORE_REG_AW-1:0] rs1_addr;
    logic [`CORE_REG_AW-1:0] rs2_addr;
    logic [`CORE_XLEN-1:0]   rs1_data;
    logic [`CORE_XLEN-1:0]   rs2_data;
    logic [`CORE_REG_AW-1:0] rf_waddr;
    logic [`CORE_XLEN-1:0]   rf_wdata;
    logic                    rf_we;

    // Stage handoff
    core_pkg::fetch_s        fetch;
    core_pkg::decode_s       decode;
    core_pkg::exec_s         exec;
    core_pkg::mem_s          mem;
    core_pkg::redirect_s     redirect;
    logic                    pc_wen;

    register_file u_register_file (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .raddr1_i (rs1_addr),
        .raddr2_i (rs2_addr),
        .waddr_i  (rf_waddr),
        .wdata_i  (rf_wdata),
        .we_i     (rf_we),
        .rdata1_o (rs1_data),
        .rdata2_o (rs2_data)
    );

    ifu u_ifu (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .redirect_i (redirect),
        .pc_wen_i   (pc_wen),
        .wb_rsp_i   (imem_rsp_i),
        .wb_req_o   (imem_req_o),
        .fetch_o    (fetch)
    );

    idu u_idu (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .fetch_i    (fetch),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .rs1_addr_o (rs1_addr),
        .rs2_addr_o (rs2_addr),
        .decode_o   (decode),
        .redirect_o (redirect)
    );

    exu u_exu (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .decode_i (decode),
        .exec_o   (exec)
    );

    lsu u_lsu (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .exec_i   (exec),
        .wb_rsp_i (dmem_rsp_i),
        .wb_req_o (dmem_req_o),
        .mem_o    (mem)
    );

    wbu u_wbu (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .mem_i          (mem),
        .rf_waddr_o     (rf_waddr),
        .rf_wdata_o     (rf_wdata),
        .rf_we_o        (rf_we),
        .pc_wen_o       (pc_wen),
        .retire_o       (retire_o),
        .retire_valid_o (retire_valid_o)
    );

endmodule

// ==== verilog/exu.sv ====
`timescale 1ns/1ps
`include "core_config.svh"

module exu (
    input  logic              clk,
    input  logic              rst_n_i,
    input  core_pkg::decode_s decode_i,
    output core_pkg::exec_s   exec_o
);

    logic [`CORE_XLEN-1:0] alu_res;
    core_pkg::exec_s       exec_q;

    always_comb begin
        case (decode_i.alu_op)
            core_pkg::ALU_SUB:   alu_res = decode_i.op1 - decode_i.op2;
            core_pkg::ALU_PASSB: alu_res = decode_i.op2;
            default:             alu_res = decode_i.op1 + decode_i.op2;
        endcase
        // Link address
        if (decode_i.opcode == core_pkg::JAL) begin
            alu_res = decode_i.pc + `CORE_XLEN'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            exec_q.valid <= 1'b0;
        end else begin
            exec_q.valid <= decode_i.valid;
            if (decode_i.valid) begin
                exec_q.pc       <= decode_i.pc;
                exec_q.result   <= alu_res;
                exec_q.rs2_data <= decode_i.rs2_data;
                exec_q.rd       <= decode_i.rd;
                exec_q.opcode   <= decode_i.opcode;
            end
        end
    end

    assign exec_o = exec_q;

endmodule

// ==== verilog/idu.sv ====
`timescale 1ns/1ps
`include "core_config.svh"

module idu (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  core_pkg::fetch_s        fetch_i,
    input  logic [`CORE_XLEN-1:0]   rs1_data_i,
    input  logic [`CORE_XLEN-1:0]   rs2_data_i,
    output logic [`CORE_REG_AW-1:0] rs1_addr_o,
    output logic [`CORE_REG_AW-1:0] rs2_addr_o,
    output core_pkg::decode_s       decode_o,
    output core_pkg::redirect_s     redirect_o
);

    logic [31:0]           inst;
    core_pkg::opcode_e     opcode;
    logic [`CORE_XLEN-1:0] imm_i;
    logic [`CORE_XLEN-1:0] imm_s;
    logic [`CORE_XLEN-1:0] imm_b;
    logic [`CORE_XLEN-1:0] imm_u;
    logic [`CORE_XLEN-1:0] imm_j;
    core_pkg::decode_s     dec_d;
    core_pkg::decode_s     dec_q;

    assign inst       = fetch_i.inst;
    assign opcode     = core_pkg::opcode_e'(inst[6:0]);
    assign rs1_addr_o = inst[19:15];
    assign rs2_addr_o = inst[24:20];

    // Immediate formats
    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        dec_d          = '0;
        dec_d.valid    = fetch_i.valid;
        dec_d.pc       = fetch_i.pc;
        dec_d.op1      = rs1_data_i;
        dec_d.op2      = imm_i;
        dec_d.rs2_data = rs2_data_i;
        dec_d.rd       = inst[11:7];
        dec_d.alu_op   = core_pkg::ALU_ADD;
        dec_d.opcode   = opcode;
        case (opcode)
            core_pkg::OP: begin
                dec_d.op2 = rs2_data_i;
                // funct7 bit 5 selects SUB
                if (inst[30]) begin
                    dec_d.alu_op = core_pkg::ALU_SUB;
                end
            end
            core_pkg::LUI: begin
                dec_d.op2    = imm_u;
                dec_d.alu_op = core_pkg::ALU_PASSB;
            end
            core_pkg::STORE: begin
                dec_d.op2 = imm_s;
                dec_d.rd  = '0;
            end
            core_pkg::BRANCH: begin
                dec_d.rd     = '0;
                dec_d.taken  = (rs1_data_i == rs2_data_i);
                dec_d.target = fetch_i.pc + imm_b;
            end
            core_pkg::JAL: begin
                dec_d.taken  = 1'b1;
                dec_d.target = fetch_i.pc + imm_j;
            end
            default: begin
                // OP_IMM and LOAD use rs1 + imm_i
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            dec_q.valid <= 1'b0;
            dec_q.taken <= 1'b0;
        end else if (fetch_i.valid) begin
            dec_q <= dec_d;
        end else begin
            dec_q.valid <= 1'b0;
        end
    end

    assign decode_o   = dec_q;
    assign redirect_o = '{taken: dec_q.taken, target: dec_q.target};

endmodule

// ==== verilog/ifu.sv ====
`timescale 1ns/1ps
`include "core_config.svh"

module ifu (
    input  logic                clk,
    input  logic                rst_n_i,
    input  core_pkg::redirect_s redirect_i,
    input  logic                pc_wen_i,
    input  core_pkg::wb_rsp_s   wb_rsp_i,
    output core_pkg::wb_req_s   wb_req_o,
    output core_pkg::fetch_s    fetch_o
);

    core_pkg::stage_state_e state_q;
    core_pkg::redirect_s    redir_q;
    logic [`CORE_XLEN-1:0]  pc_q;
    logic [`CORE_XLEN-1:0]  pc_next;
    logic [31:0]            inst_q;
    logic                   cyc_q;
    logic                   valid_q;

    assign pc_next = redir_q.taken ? redir_q.target : pc_q + `CORE_XLEN'd4;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q       <= core_pkg::FETCH_REQ;
            pc_q          <= `CORE_RESET_PC;
            cyc_q         <= 1'b0;
            valid_q       <= 1'b0;
            redir_q.taken <= 1'b0;
        end else begin
            valid_q <= 1'b0;
            case (state_q)
                // First request after reset
                core_pkg::FETCH_REQ: begin
                    cyc_q   <= 1'b1;
                    state_q <= core_pkg::FETCH_WAIT;
                end
                core_pkg::FETCH_WAIT: begin
                    if (wb_rsp_i.ack) begin
                        cyc_q   <= 1'b0;
                        inst_q  <= wb_rsp_i.dat_r;
                        valid_q <= 1'b1;
                        state_q <= core_pkg::IDLE;
                    end
                end
                default: begin
                    // Track the IDU redirect until write-back retires the instruction
                    redir_q <= redirect_i;
                    if (pc_wen_i) begin
                        pc_q    <= pc_next;
                        cyc_q   <= 1'b1;
                        state_q <= core_pkg::FETCH_WAIT;
                    end
                end
            endcase
        end
    end

    assign wb_req_o = '{cyc: cyc_q, stb: cyc_q, we: 1'b0, adr: pc_q, dat_w: '0, sel: 4'hF};
    assign fetch_o  = '{valid: valid_q, pc: pc_q, inst: inst_q};

endmodule

// ==== verilog/lsu.sv ====
`timescale 1ns/1ps
`include "core_config.svh"

module lsu (
    input  logic              clk,
    input  logic              rst_n_i,
    input  core_pkg::exec_s   exec_i,
    input  core_pkg::wb_rsp_s wb_rsp_i,
    output core_pkg::wb_req_s wb_req_o,
    output core_pkg::mem_s    mem_o
);

    core_pkg::stage_state_e state_q;
    core_pkg::exec_s        ex_q;
    logic [`CORE_XLEN-1:0]  load_q;
    logic                   cyc_q;
    logic                   mem_valid_q;
    logic                   is_mem;

    assign is_mem = (exec_i.opcode == core_pkg::LOAD) || (exec_i.opcode == core_pkg::STORE);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q     <= core_pkg::IDLE;
            cyc_q       <= 1'b0;
            mem_valid_q <= 1'b0;
        end else begin
            mem_valid_q <= 1'b0;
            case (state_q)
                core_pkg::IDLE: begin
                    if (exec_i.valid) begin
                        if (is_mem) begin
                            cyc_q   <= 1'b1;
                            state_q <= core_pkg::ACCESS;
                        end else begin
                            mem_valid_q <= 1'b1;
                        end
                    end
                end
                core_pkg::ACCESS: begin
                    if (wb_rsp_i.ack) begin
                        cyc_q       <= 1'b0;
                        mem_valid_q <= 1'b1;
                        state_q     <= core_pkg::DONE;
                    end
                end
                default: state_q <= core_pkg::IDLE;
            endcase
        end
    end

    // Payload capture
    always_ff @(posedge clk) begin
        if ((state_q == core_pkg::IDLE) && exec_i.valid) begin
            ex_q <= exec_i;
        end
        if ((state_q == core_pkg::ACCESS) && wb_rsp_i.ack) begin
            load_q <= wb_rsp_i.dat_r;
        end
    end

    // Word accesses only
    assign wb_req_o = '{cyc: cyc_q, stb: cyc_q, we: (ex_q.opcode == core_pkg::STORE),
                        adr: ex_q.result, dat_w: ex_q.rs2_data, sel: 4'hF};

    assign mem_o = '{valid: mem_valid_q, pc: ex_q.pc, result: ex_q.result,
                     load_data: load_q, rd: ex_q.rd, opcode: ex_q.opcode};

endmodule

// ==== verilog/register_file.sv ====
`timescale 1ns/1ps
`include "core_config.svh"

module register_file (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic [`CORE_REG_AW-1:0] raddr1_i,
    input  logic [`CORE_REG_AW-1:0] raddr2_i,
    input  logic [`CORE_REG_AW-1:0] waddr_i,
    input  logic [`CORE_XLEN-1:0]   wdata_i,
    input  logic                    we_i,
    output logic [`CORE_XLEN-1:0]   rdata1_o,
    output logic [`CORE_XLEN-1:0]   rdata2_o
);

    logic [`CORE_XLEN-1:0] regs [0:(1 << `CORE_REG_AW)-1];

    // x0 is never written
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < (1 << `CORE_REG_AW); i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (waddr_i != `CORE_REG_X0)) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // Combinational reads return the old value during a same-cycle write
    assign rdata1_o = (raddr1_i == `CORE_REG_X0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == `CORE_REG_X0) ? '0 : regs[raddr2_i];

endmodule

// ==== verilog/wbu.sv ====
`timescale 1ns/1ps
`include "core_config.svh"

module wbu (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  core_pkg::mem_s          mem_i,
    output logic [`CORE_REG_AW-1:0] rf_waddr_o,
    output logic [`CORE_XLEN-1:0]   rf_wdata_o,
    output logic                    rf_we_o,
    output logic                    pc_wen_o,
    output core_pkg::retire_s       retire_o,
    output logic                    retire_valid_o
);

    logic                    valid_q;
    logic                    we_q;
    logic                    we_d;
    logic [`CORE_REG_AW-1:0] rd_q;
    logic [`CORE_XLEN-1:0]   wdata_q;
    logic [`CORE_XLEN-1:0]   wdata_d;
    logic [`CORE_XLEN-1:0]   pc_q;

    assign wdata_d = (mem_i.opcode == core_pkg::LOAD) ? mem_i.load_data : mem_i.result;

    // Stores, branches and x0 targets leave the register file alone
    assign we_d = (mem_i.opcode != core_pkg::STORE) && (mem_i.opcode != core_pkg::BRANCH)
                  && (mem_i.rd != `CORE_REG_X0);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
            we_q    <= 1'b0;
        end else begin
            valid_q <= mem_i.valid;
            we_q    <= mem_i.valid && we_d;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_i.valid) begin
            rd_q    <= mem_i.rd;
            wdata_q <= wdata_d;
            pc_q    <= mem_i.pc;
        end
    end

    assign rf_waddr_o     = rd_q;
    assign rf_wdata_o     = wdata_q;
    assign rf_we_o        = we_q;
    assign pc_wen_o       = valid_q;
    assign retire_valid_o = valid_q;
    assign retire_o       = '{pc: pc_q, rd: rd_q, we: we_q, wdata: wdata_q};

endmodule
